//--- hdl/bpu_pkg.sv
package bpu_pkg;

    // datapath widths
    localparam int xlen   = 32;
    localparam int hist_w = 16;   // global history length

    // base table, indexed by pc[9:1]
    localparam int bim_entries = 512;

    // tagged history tables
    localparam int tag_entries = 256;
    localparam int tag_idx_w   = 8;
    localparam int tag_w       = 10;

    // branch target buffer, indexed by pc[9:2], tag is pc[31:10]
    localparam int btb_entries = 256;
    localparam int btb_tag_w   = 22;

    // weak not-taken
    localparam logic [1:0] ctr_reset = 2'b01;

    // rv32 major opcodes of control instructions
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // class of the fetched instruction
    typedef enum logic [1:0] {
        cls_none,
        cls_branch,
        cls_jal,
        cls_jalr
    } inst_class_e;

    // write command to one tagged table
    typedef enum logic [1:0] {
        op_none,
        op_train,       // saturate counter toward outcome
        op_set_strong,  // jump to strong state of outcome
        op_allocate     // claim entry with weak counter
    } tage_op_e;

    // 2-bit saturating step toward the outcome
    function automatic logic [1:0] ctr_step(input logic [1:0] ctr, input logic taken);
        logic [1:0] nxt;
        nxt = ctr;
        if (taken && ctr != 2'b11) begin
            nxt = ctr + 2'b01;
        end else if (!taken && ctr != 2'b00) begin
            nxt = ctr - 2'b01;
        end
        return nxt;
    endfunction

endpackage

//--- hdl/bimodal_table.sv
`timescale 1ns/1ps

module bimodal_table (
    input  logic                     clk,
    input  logic                     rst,
    // lookup
    input  logic [bpu_pkg::xlen-1:0] look_pc_i,
    output logic                     look_taken_o,
    // training
    input  logic                     upd_en_i,
    input  logic [bpu_pkg::xlen-1:0] upd_pc_i,
    input  logic                     upd_taken_i
);
    import bpu_pkg::*;

    logic [1:0] ctr_q [bim_entries];

    logic [$clog2(bim_entries)-1:0] look_idx;
    logic [$clog2(bim_entries)-1:0] upd_idx;

    // halfword granule, so compressed code spreads over the table
    assign look_idx = look_pc_i[$clog2(bim_entries):1];
    assign upd_idx  = upd_pc_i[$clog2(bim_entries):1];

    assign look_taken_o = ctr_q[look_idx][1];  // msb is the direction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bim_entries; i++) begin
                ctr_q[i] <= ctr_reset;
            end
        end else if (upd_en_i) begin
            ctr_q[upd_idx] <= ctr_step(ctr_q[upd_idx], upd_taken_i);
        end
    end

endmodule

//--- hdl/tagged_table.sv
`timescale 1ns/1ps

module tagged_table #(
    parameter int idx_hist_lsb = 0,  // first history bit folded into index
    parameter int tag_hist_lsb = 6   // first history bit folded into tag
) (
    input  logic                       clk,
    input  logic                       rst,
    // lookup port, fetch side
    input  logic [bpu_pkg::xlen-1:0]   look_pc_i,
    input  logic [bpu_pkg::hist_w-1:0] look_hist_i,
    output logic                       look_hit_o,
    output logic                       look_taken_o,
    // update port, execute side
    input  logic [bpu_pkg::xlen-1:0]   upd_pc_i,
    input  logic [bpu_pkg::hist_w-1:0] upd_hist_i,
    output logic                       upd_hit_o,
    input  bpu_pkg::tage_op_e          upd_op_i,
    input  logic                       upd_taken_i
);
    import bpu_pkg::*;

    logic [tag_w-1:0] tag_q   [tag_entries];
    logic [1:0]       ctr_q   [tag_entries];
    logic             valid_q [tag_entries];

    logic [tag_idx_w-1:0] look_idx;
    logic [tag_idx_w-1:0] upd_idx;
    logic [tag_w-1:0]     look_tag;
    logic [tag_w-1:0]     upd_tag;

    function automatic logic [tag_idx_w-1:0] fold_idx(input logic [xlen-1:0] pc,
                                                      input logic [hist_w-1:0] h);
        return pc[tag_idx_w-1:0] ^ h[idx_hist_lsb +: tag_idx_w];
    endfunction

    // tag history window wraps around the top of the register
    function automatic logic [tag_w-1:0] fold_tag(input logic [xlen-1:0] pc,
                                                  input logic [hist_w-1:0] h);
        logic [2*hist_w-1:0] dbl;
        dbl = {h, h} >> tag_hist_lsb;
        return pc[tag_idx_w +: tag_w] ^ dbl[tag_w-1:0];
    endfunction

    assign look_idx = fold_idx(look_pc_i, look_hist_i);
    assign look_tag = fold_tag(look_pc_i, look_hist_i);
    assign upd_idx  = fold_idx(upd_pc_i, upd_hist_i);
    assign upd_tag  = fold_tag(upd_pc_i, upd_hist_i);

    assign look_hit_o   = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
    assign look_taken_o = ctr_q[look_idx][1];
    assign upd_hit_o    = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);

    // counters and valid bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tag_entries; i++) begin
                ctr_q[i]   <= ctr_reset;
                valid_q[i] <= 1'b0;
            end
        end else begin
            case (upd_op_i)
                op_train:      ctr_q[upd_idx] <= ctr_step(ctr_q[upd_idx], upd_taken_i);
                op_set_strong: ctr_q[upd_idx] <= upd_taken_i ? 2'b11 : 2'b00;
                op_allocate: begin
                    ctr_q[upd_idx]   <= upd_taken_i ? 2'b10 : 2'b01;  // weak toward outcome
                    valid_q[upd_idx] <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // tag storage, only meaningful under valid
    always_ff @(posedge clk) begin
        if (upd_op_i == op_allocate) begin
            tag_q[upd_idx] <= upd_tag;
        end
    end

endmodule

//--- hdl/target_buffer.sv
`timescale 1ns/1ps

module target_buffer (
    input  logic                     clk,
    input  logic                     rst,
    // lookup
    input  logic [bpu_pkg::xlen-1:0] look_pc_i,
    output logic                     hit_o,
    output logic [bpu_pkg::xlen-1:0] target_o,
    // write on taken resolution
    input  logic                     upd_en_i,
    input  logic [bpu_pkg::xlen-1:0] upd_pc_i,
    input  logic [bpu_pkg::xlen-1:0] upd_target_i
);
    import bpu_pkg::*;

    localparam int idx_w = $clog2(btb_entries);

    logic [btb_tag_w-1:0] tag_q    [btb_entries];
    logic [xlen-1:0]      target_q [btb_entries];
    logic                 valid_q  [btb_entries];

    logic [idx_w-1:0]     look_idx;
    logic [idx_w-1:0]     upd_idx;
    logic [btb_tag_w-1:0] look_tag;
    logic [btb_tag_w-1:0] upd_tag;

    // word index, everything above is tag
    assign look_idx = look_pc_i[idx_w+1:2];
    assign upd_idx  = upd_pc_i[idx_w+1:2];
    assign look_tag = look_pc_i[xlen-1 -: btb_tag_w];
    assign upd_tag  = upd_pc_i[xlen-1 -: btb_tag_w];

    assign hit_o    = valid_q[look_idx] && (tag_q[look_idx] == look_tag);
    assign target_o = target_q[look_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_en_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (upd_en_i) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

//--- hdl/predict_ctrl.sv
`timescale 1ns/1ps

module predict_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // fetch
    input  logic [bpu_pkg::xlen-1:0]   if_pc_i,
    input  logic [bpu_pkg::xlen-1:0]   if_inst_i,
    // execute feedback
    input  logic                       ex_valid_i,
    input  logic                       ex_taken_i,
    input  logic                       ex_correct_i,
    input  logic [bpu_pkg::xlen-1:0]   ex_pc_i,
    input  logic [bpu_pkg::hist_w-1:0] ex_hist_i,
    input  logic [bpu_pkg::xlen-1:0]   ex_target_i,
    // prediction out
    output logic                       is_branch_o,
    output logic                       pred_taken_o,
    output logic [bpu_pkg::xlen-1:0]   pred_pc_o,
    output logic [bpu_pkg::hist_w-1:0] hist_o,
    // lookup side of the tables
    output logic [bpu_pkg::xlen-1:0]   look_pc_o,
    output logic [bpu_pkg::hist_w-1:0] look_hist_o,
    input  logic                       bim_taken_i,
    input  logic                       ts_hit_i,
    input  logic                       ts_taken_i,
    input  logic                       tl_hit_i,
    input  logic                       tl_taken_i,
    input  logic                       btb_hit_i,
    input  logic [bpu_pkg::xlen-1:0]   btb_target_i,
    // update side of the tables
    output logic [bpu_pkg::xlen-1:0]   upd_pc_o,
    output logic [bpu_pkg::hist_w-1:0] upd_hist_o,
    output logic                       upd_taken_o,
    output logic                       bim_upd_en_o,
    output logic                       btb_upd_en_o,
    output logic [bpu_pkg::xlen-1:0]   btb_upd_target_o,
    input  logic                       ts_upd_hit_i,
    input  logic                       tl_upd_hit_i,
    output bpu_pkg::tage_op_e          ts_op_o,
    output bpu_pkg::tage_op_e          tl_op_o
);
    import bpu_pkg::*;

    inst_class_e       cls;
    logic [hist_w-1:0] hist_q;
    logic [xlen-1:0]   j_imm;
    logic [xlen-1:0]   b_imm;
    logic              dir;

    always_comb begin
        case (if_inst_i[6:0])
            opc_branch: cls = cls_branch;
            opc_jal:    cls = cls_jal;
            opc_jalr:   cls = cls_jalr;
            default:    cls = cls_none;
        endcase
    end

    assign j_imm = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                    if_inst_i[30:21], 1'b0};
    assign b_imm = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                    if_inst_i[11:8], 1'b0};

    // long table over short table over base
    assign dir = tl_hit_i ? tl_taken_i : (ts_hit_i ? ts_taken_i : bim_taken_i);

    always_comb begin
        is_branch_o  = (cls != cls_none);
        pred_taken_o = 1'b0;
        pred_pc_o    = if_pc_i + 32'd4;
        case (cls)
            cls_jal: begin
                pred_taken_o = 1'b1;
                pred_pc_o    = btb_hit_i ? btb_target_i : if_pc_i + j_imm;
            end
            cls_jalr: begin
                // no other target source for indirect jumps
                if (btb_hit_i) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = btb_target_i;
                end
            end
            cls_branch: begin
                if (dir) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = btb_hit_i ? btb_target_i : if_pc_i + b_imm;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (ex_valid_i) begin
            hist_q <= {hist_q[hist_w-2:0], ex_taken_i};  // newest outcome in bit 0
        end
    end

    assign hist_o      = hist_q;
    assign look_pc_o   = if_pc_i;
    assign look_hist_o = hist_q;

    // training uses the history sampled at prediction time
    assign upd_pc_o         = ex_pc_i;
    assign upd_hist_o       = ex_hist_i;
    assign upd_taken_o      = ex_taken_i;
    assign bim_upd_en_o     = ex_valid_i;
    assign btb_upd_en_o     = ex_valid_i && ex_taken_i;
    assign btb_upd_target_o = ex_target_i;

    always_comb begin
        ts_op_o = op_none;
        tl_op_o = op_none;
        if (ex_valid_i) begin
            if (tl_upd_hit_i) begin                 // long table provided
                tl_op_o = ex_correct_i ? op_train : op_set_strong;
            end else if (ts_upd_hit_i) begin        // short table provided
                ts_op_o = ex_correct_i ? op_train : op_set_strong;
            end else if (!ex_correct_i) begin
                // base was wrong and neither tagged table holds this branch
                tl_op_o = op_allocate;
            end
        end
    end

endmodule

//--- hdl/bpu_top.sv
`timescale 1ns/1ps

module bpu_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::xlen-1:0]   if_pc_i,
    input  logic [bpu_pkg::xlen-1:0]   if_inst_i,
    input  logic                       ex_valid_i,
    input  logic                       ex_taken_i,
    input  logic                       ex_correct_i,
    input  logic [bpu_pkg::xlen-1:0]   ex_pc_i,
    input  logic [bpu_pkg::hist_w-1:0] ex_hist_i,
    input  logic [bpu_pkg::xlen-1:0]   ex_target_i,
    output logic                       is_branch_o,
    output logic                       pred_taken_o,
    output logic [bpu_pkg::xlen-1:0]   pred_pc_o,
    output logic [bpu_pkg::hist_w-1:0] hist_o
);
    import bpu_pkg::*;

    logic [xlen-1:0]   look_pc;
    logic [hist_w-1:0] look_hist;
    logic [xlen-1:0]   upd_pc;
    logic [hist_w-1:0] upd_hist;
    logic              upd_taken;
    logic              bim_taken;
    logic              bim_upd_en;
    logic              ts_hit;
    logic              ts_taken;
    logic              ts_upd_hit;
    tage_op_e          ts_op;
    logic              tl_hit;
    logic              tl_taken;
    logic              tl_upd_hit;
    tage_op_e          tl_op;
    logic              btb_hit;
    logic [xlen-1:0]   btb_target;
    logic              btb_upd_en;
    logic [xlen-1:0]   btb_upd_target;

    bimodal_table bim_i (
        .clk, .rst,
        .look_pc_i(look_pc), .look_taken_o(bim_taken),
        .upd_en_i(bim_upd_en), .upd_pc_i(upd_pc), .upd_taken_i(upd_taken)
    );

    predict_ctrl ctrl_i (
        .clk, .rst, .if_pc_i, .if_inst_i,
        .ex_valid_i, .ex_taken_i, .ex_correct_i, .ex_pc_i, .ex_hist_i, .ex_target_i,
        .is_branch_o, .pred_taken_o, .pred_pc_o, .hist_o,
        .look_pc_o(look_pc), .look_hist_o(look_hist),
        .bim_taken_i(bim_taken), .ts_hit_i(ts_hit), .ts_taken_i(ts_taken),
        .tl_hit_i(tl_hit), .tl_taken_i(tl_taken),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target),
        .upd_pc_o(upd_pc), .upd_hist_o(upd_hist), .upd_taken_o(upd_taken),
        .bim_upd_en_o(bim_upd_en), .btb_upd_en_o(btb_upd_en),
        .btb_upd_target_o(btb_upd_target),
        .ts_upd_hit_i(ts_upd_hit), .tl_upd_hit_i(tl_upd_hit),
        .ts_op_o(ts_op), .tl_op_o(tl_op)
    );

    // short history: index 7:0, tag 15:6
    tagged_table #(.idx_hist_lsb(0), .tag_hist_lsb(6)) t_short_i (
        .clk, .rst,
        .look_pc_i(look_pc), .look_hist_i(look_hist),
        .look_hit_o(ts_hit), .look_taken_o(ts_taken),
        .upd_pc_i(upd_pc), .upd_hist_i(upd_hist), .upd_hit_o(ts_upd_hit),
        .upd_op_i(ts_op), .upd_taken_i(upd_taken)
    );

    // long history: index 15:8, tag 9:0
    tagged_table #(.idx_hist_lsb(8), .tag_hist_lsb(0)) t_long_i (
        .clk, .rst,
        .look_pc_i(look_pc), .look_hist_i(look_hist),
        .look_hit_o(tl_hit), .look_taken_o(tl_taken),
        .upd_pc_i(upd_pc), .upd_hist_i(upd_hist), .upd_hit_o(tl_upd_hit),
        .upd_op_i(tl_op), .upd_taken_i(upd_taken)
    );

    target_buffer btb_i (
        .clk, .rst,
        .look_pc_i(look_pc), .hit_o(btb_hit), .target_o(btb_target),
        .upd_en_i(btb_upd_en), .upd_pc_i(upd_pc), .upd_target_i(btb_upd_target)
    );

endmodule

//--- verif/bpu_properties.sv
`timescale 1ns/1ps

module bpu_properties (
    input logic                       clk,
    input logic                       rst,
    input logic [bpu_pkg::xlen-1:0]   if_pc_i,
    input logic                       ex_valid_i,
    input logic                       is_branch_i,
    input logic                       pred_taken_i,
    input logic [bpu_pkg::xlen-1:0]   pred_pc_i,
    input logic [bpu_pkg::hist_w-1:0] hist_i
);
    int fail_taken = 0;
    int fail_seq_pc = 0;
    int fail_hist = 0;

    taken_needs_branch: assert property (
        @(posedge clk) disable iff (rst) pred_taken_i |-> is_branch_i
    ) else begin
        $error("taken prediction for a non-control instruction");
        fail_taken = fail_taken + 1;
    end

    // plain instructions fall through
    seq_pc_for_plain: assert property (
        @(posedge clk) disable iff (rst) !is_branch_i |-> pred_pc_i == if_pc_i + 32'd4
    ) else begin
        $error("non-control instruction did not predict pc+4");
        fail_seq_pc = fail_seq_pc + 1;
    end

    hist_holds: assert property (
        @(posedge clk) disable iff (rst) !ex_valid_i |=> $stable(hist_i)
    ) else begin
        $error("global history moved without feedback");
        fail_hist = fail_hist + 1;
    end

endmodule

bind bpu_top bpu_properties props_i (
    .clk(clk),
    .rst(rst),
    .if_pc_i(if_pc_i),
    .ex_valid_i(ex_valid_i),
    .is_branch_i(is_branch_o),
    .pred_taken_i(pred_taken_o),
    .pred_pc_i(pred_pc_o),
    .hist_i(hist_o)
);

//--- verif/tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu;
    import bpu_pkg::*;

    localparam int    clk_period    = 20;
    localparam int    reset_cycles  = 4;
    localparam int    margin_cycles = 50;
    localparam string input_path    = "verif/bpu_input.txt";

    logic              clk = 1'b0;
    logic              rst;
    logic [xlen-1:0]   if_pc;
    logic [xlen-1:0]   if_inst;
    logic              ex_valid;
    logic              ex_taken;
    logic              ex_correct;
    logic [xlen-1:0]   ex_pc;
    logic [hist_w-1:0] ex_hist;
    logic [xlen-1:0]   ex_target;
    logic              is_branch;
    logic              pred_taken;
    logic [xlen-1:0]   pred_pc;
    logic [hist_w-1:0] hist;

    string lines [$];
    bit    loaded = 1'b0;
    int    n_tests = 0;
    int    n_checks = 0;
    int    n_errors = 0;
    int    test_num = 0;
    int    test_checks = 0;
    int    test_errors = 0;

    bpu_top dut_i (
        .clk(clk), .rst(rst),
        .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_valid_i(ex_valid), .ex_taken_i(ex_taken), .ex_correct_i(ex_correct),
        .ex_pc_i(ex_pc), .ex_hist_i(ex_hist), .ex_target_i(ex_target),
        .is_branch_o(is_branch), .pred_taken_o(pred_taken),
        .pred_pc_o(pred_pc), .hist_o(hist)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        n_checks++;
        test_checks++;
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            n_errors++;
            test_errors++;
        end
    endtask

    // keeps stimulus lines, drops comments and blank lines
    task automatic read_stimulus(output bit ok);
        int    fd;
        string line;
        fd = $fopen(input_path, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic close_test();
        if (test_num > 0) begin
            $display("test %0d done: %0d checks, %0d errors", test_num, test_checks,
                     test_errors);
            n_tests++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // one execute-stage strobe, sampled at the next edge
    task automatic send_feedback(input string body);
        logic              taken;
        logic              correct;
        logic [xlen-1:0]   pc;
        logic [hist_w-1:0] h;
        logic [xlen-1:0]   target;
        int                n;
        n = $sscanf(body, "%h %h %h %h %h", taken, correct, pc, h, target);
        @(posedge clk);
        #2;
        ex_valid = (n == 5);
        ex_taken = taken;
        ex_correct = correct;
        ex_pc = pc;
        ex_hist = h;
        ex_target = target;
        if (n != 5) begin
            $display("malformed update line in stimulus file: %s", body);
            n_errors++;
            test_errors++;
        end
    endtask

    task automatic probe_fetch(input string body);
        logic [xlen-1:0]   pc;
        logic [xlen-1:0]   inst;
        logic              exp_br;
        logic              exp_taken;
        logic [xlen-1:0]   exp_pc;
        logic [hist_w-1:0] exp_hist;
        int                n;
        n = $sscanf(body, "%h %h %h %h %h %h", pc, inst, exp_br, exp_taken, exp_pc, exp_hist);
        @(posedge clk);
        #2;
        ex_valid = 1'b0;
        if_pc = pc;
        if_inst = inst;
        @(negedge clk);  // prediction is combinational, settled by now
        if (n != 6) begin
            $display("malformed lookup line in stimulus file: %s", body);
            n_errors++;
            test_errors++;
        end else begin
            compare_value("is_branch_o", 32'(is_branch), 32'(exp_br));
            compare_value("pred_taken_o", 32'(pred_taken), 32'(exp_taken));
            compare_value("pred_pc_o", pred_pc, exp_pc);
            compare_value("hist_o", 32'(hist), 32'(exp_hist));
        end
    endtask

    initial begin
        bit    ok;
        byte   kind;
        string line;
        int    asrt_fails;
        rst = 1'b1;
        if_pc = '0;
        if_inst = '0;
        ex_valid = 1'b0;
        ex_taken = 1'b0;
        ex_correct = 1'b0;
        ex_pc = '0;
        ex_hist = '0;
        ex_target = '0;
        read_stimulus(ok);
        repeat (reset_cycles) @(posedge clk);
        #2 rst = 1'b0;
        if (!ok) begin
            $display("could not open stimulus file %s", input_path);
            n_errors++;
        end else begin
            loaded = 1'b1;
            foreach (lines[i]) begin
                line = lines[i];
                kind = line.getc(0);
                case (kind)
                    "T": begin
                        close_test();
                        void'($sscanf(line.substr(1, line.len() - 1), "%d", test_num));
                    end
                    "U": send_feedback(line.substr(1, line.len() - 1));
                    "L": probe_fetch(line.substr(1, line.len() - 1));
                    default: begin
                        $display("unknown line kind %c in stimulus file", kind);
                        n_errors++;
                    end
                endcase
            end
            @(posedge clk);
            #2 ex_valid = 1'b0;
            close_test();
        end
        asrt_fails = dut_i.props_i.fail_taken + dut_i.props_i.fail_seq_pc
                   + dut_i.props_i.fail_hist;
        if (asrt_fails > 0) begin
            $display("%0d failures of the bound assertions", asrt_fails);
            n_errors += asrt_fails;
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // one clock per stimulus line plus reset and slack
    initial begin
        int limit;
        wait (loaded);
        limit = (lines.size() + reset_cycles + margin_cycles) * clk_period;
        #(limit);
        $display("timeout: stimulus did not complete within %0d ns", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verif/bpu_input.txt
# update: U taken correct ex_pc ex_hist ex_target, new test: T number
# lookup: L if_pc if_inst exp_is_branch exp_taken exp_pred_pc exp_hist
T 1
L 00001000 00100093 0 0 00001004 0000
T 2
L 00002000 1000006f 1 1 00002100 0000
L 00003010 04000063 1 0 00003014 0000
L 00003100 00008067 1 0 00003104 0000
T 3
U 1 0 00003020 0000 00003060
L 00003020 04000063 1 1 00003060 0001
L 00003420 fe0008e3 1 1 00003410 0001
T 4
U 1 1 00004040 0001 00004abc
L 00004040 1000006f 1 1 00004abc 0003
L 00004040 00008067 1 1 00004abc 0003
L 00004440 00008067 1 0 00004444 0003
T 5
U 0 1 00005080 0003 00000000
L 00001000 00100093 0 0 00001004 0006
U 1 1 00005080 0006 00005000
L 00001000 00100093 0 0 00001004 000d
U 0 1 00005080 000d 00000000
L 00001000 00100093 0 0 00001004 001a
U 1 1 00005080 001a 00005000
U 1 1 00005080 0035 00005000
L 00001000 00100093 0 0 00001004 006b
T 6
U 0 1 00006100 006b 00000000
U 1 0 00006100 01ad 00006140
L 00006100 04000063 1 1 00006140 01ad
U 0 1 00005080 01ad 00000000
L 00006100 04000063 1 0 00006104 035a

//--- all.f
hdl/bpu_pkg.sv
hdl/bimodal_table.sv
hdl/tagged_table.sv
hdl/target_buffer.sv
hdl/predict_ctrl.sv
hdl/bpu_top.sv
verif/bpu_properties.sv
verif/tb_bpu.sv

//--- Makefile
TOP := tb_bpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
